//--- rtl/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// datapath and CSR number widths
`define DATA_WIDTH      32
`define CSR_ADDR_WIDTH  12

// mstatus comes out of reset with MPP fixed to machine mode
`define MSTATUS_RESET   32'h0000_1800

// only MIE and MPIE can be written, everything else keeps its reset value
`define MSTATUS_WMASK   32'h0000_0088

`define MSTATUS_MIE_BIT   3
`define MSTATUS_MPIE_BIT  7

`endif

//--- rtl/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

  // Zicsr operation issued by the decoder
  typedef enum logic [1:0] {
    CSR_NONE = 2'd0,  // no CSR instruction this cycle
    CSR_RW   = 2'd1,  // write the operand
    CSR_RS   = 2'd2,  // set the operand bits
    CSR_RC   = 2'd3   // clear the operand bits
  } csr_op_e;

  // machine-mode CSR numbers kept by this block
  typedef enum logic [`CSR_ADDR_WIDTH-1:0] {
    CSR_MSTATUS  = 12'h300,
    CSR_MTVEC    = 12'h305,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC     = 12'h341,
    CSR_MCAUSE   = 12'h342
  } csr_addr_e;

endpackage

//--- rtl/csr_exec.sv
`include "csr_config.svh"

module csr_exec (
  input  csr_pkg::csr_op_e              csr_op_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]    csr_addr_i,
  input  logic [`DATA_WIDTH-1:0]        csr_wdata_i,
  input  logic [`DATA_WIDTH-1:0]        old_data_i,
  input  logic                          trap_active_i,
  output logic                          csr_illegal_o,
  output logic                          wr_valid_o,
  output logic [`DATA_WIDTH-1:0]        wr_data_o
);

  import csr_pkg::*;

  logic addr_hit;
  logic op_active;

  // only the five machine-mode registers are implemented
  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS,
      CSR_MTVEC,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE: addr_hit = 1'b1;
      default:    addr_hit = 1'b0;
    endcase
  end

  assign op_active = (csr_op_i != CSR_NONE);

  assign csr_illegal_o = op_active && !addr_hit;  // unknown CSR number

  // a trap or mret in the same cycle squashes the instruction write
  assign wr_valid_o = op_active && addr_hit && !trap_active_i;

  always_comb begin
    case (csr_op_i)
      CSR_RW:  wr_data_o = csr_wdata_i;
      CSR_RS:  wr_data_o = old_data_i | csr_wdata_i;
      CSR_RC:  wr_data_o = old_data_i & ~csr_wdata_i;
      default: wr_data_o = old_data_i;  // no strobe, value is don't care
    endcase
  end

endmodule

//--- rtl/csr_trap_ctrl.sv
`include "csr_config.svh"

module csr_trap_ctrl (
  input  logic                    trap_i,
  input  logic                    mret_i,
  input  logic [`DATA_WIDTH-1:0]  trap_pc_i,
  input  logic [`DATA_WIDTH-1:0]  trap_cause_i,
  input  logic [`DATA_WIDTH-1:0]  mstatus_i,
  input  logic [`DATA_WIDTH-1:0]  mepc_i,
  input  logic [`DATA_WIDTH-1:0]  mtvec_i,
  output logic                    trap_active_o,
  output logic                    mstatus_valid_o,
  output logic [`DATA_WIDTH-1:0]  mstatus_data_o,
  output logic                    mepc_valid_o,
  output logic [`DATA_WIDTH-1:0]  mepc_data_o,
  output logic                    mcause_valid_o,
  output logic [`DATA_WIDTH-1:0]  mcause_data_o,
  output logic                    redirect_valid_o,
  output logic [`DATA_WIDTH-1:0]  redirect_pc_o
);

  logic do_trap;
  logic do_mret;

  assign do_trap = trap_i;
  assign do_mret = mret_i && !trap_i;  // trap wins when both pulse

  assign trap_active_o = do_trap || do_mret;

  // the interrupt enable stack is one level deep
  always_comb begin
    mstatus_data_o = mstatus_i;
    if (do_trap) begin
      mstatus_data_o[`MSTATUS_MPIE_BIT] = mstatus_i[`MSTATUS_MIE_BIT];
      mstatus_data_o[`MSTATUS_MIE_BIT]  = 1'b0;
    end else if (do_mret) begin
      mstatus_data_o[`MSTATUS_MIE_BIT]  = mstatus_i[`MSTATUS_MPIE_BIT];
      mstatus_data_o[`MSTATUS_MPIE_BIT] = 1'b1;
    end
  end

  assign mstatus_valid_o = do_trap || do_mret;

  assign mepc_valid_o = do_trap;
  assign mepc_data_o  = {trap_pc_i[`DATA_WIDTH-1:2], 2'b00};  // pc of the trapping instruction

  assign mcause_valid_o = do_trap;
  assign mcause_data_o  = trap_cause_i;

  // fetch redirect in direct mode only
  always_comb begin
    redirect_valid_o = 1'b0;
    redirect_pc_o    = '0;
    if (do_trap) begin
      redirect_valid_o = 1'b1;
      redirect_pc_o    = {mtvec_i[`DATA_WIDTH-1:2], 2'b00};
    end else if (do_mret) begin
      redirect_valid_o = 1'b1;
      redirect_pc_o    = mepc_i;
    end
  end

endmodule

//--- rtl/csr_regfile.sv
`include "csr_config.svh"

module csr_regfile (
  input  logic                        clk,
  input  logic                        reset_i,

  // dedicated channels from the trap logic
  input  logic                        csr_mstatus_write_valid_i,
  input  logic [`DATA_WIDTH-1:0]      csr_mstatus_write_data_i,
  input  logic                        csr_mepc_write_valid_i,
  input  logic [`DATA_WIDTH-1:0]      csr_mepc_write_data_i,
  input  logic                        csr_mcause_write_valid_i,
  input  logic [`DATA_WIDTH-1:0]      csr_mcause_write_data_i,

  // addressed port for CSR instructions
  input  logic                        csr_write_valid_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]  csr_write_addr_i,
  input  logic [`DATA_WIDTH-1:0]      csr_write_data_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]  csr_read_addr_i,
  output logic [`DATA_WIDTH-1:0]      csr_read_data_o,

  output logic [`DATA_WIDTH-1:0]      csr_mstatus_o,
  output logic [`DATA_WIDTH-1:0]      csr_mepc_o,
  output logic [`DATA_WIDTH-1:0]      csr_mtvec_o
);

  import csr_pkg::*;

  localparam logic [`DATA_WIDTH-1:0] ALIGN_MASK = {{(`DATA_WIDTH-2){1'b1}}, 2'b00};

  logic [`DATA_WIDTH-1:0] mstatus_q;
  logic [`DATA_WIDTH-1:0] mtvec_q;
  logic [`DATA_WIDTH-1:0] mscratch_q;
  logic [`DATA_WIDTH-1:0] mepc_q;
  logic [`DATA_WIDTH-1:0] mcause_q;

  logic sel_mstatus;
  logic sel_mtvec;
  logic sel_mscratch;
  logic sel_mepc;
  logic sel_mcause;

  logic mstatus_en;
  logic mepc_en;
  logic mcause_en;

  logic [`DATA_WIDTH-1:0] mstatus_din;
  logic [`DATA_WIDTH-1:0] mepc_din;
  logic [`DATA_WIDTH-1:0] mcause_din;

  // write decode on the write address
  assign sel_mstatus  = csr_write_valid_i && (csr_write_addr_i == CSR_MSTATUS);
  assign sel_mtvec    = csr_write_valid_i && (csr_write_addr_i == CSR_MTVEC);
  assign sel_mscratch = csr_write_valid_i && (csr_write_addr_i == CSR_MSCRATCH);
  assign sel_mepc     = csr_write_valid_i && (csr_write_addr_i == CSR_MEPC);
  assign sel_mcause   = csr_write_valid_i && (csr_write_addr_i == CSR_MCAUSE);

  // the trap channel beats the instruction port on each register
  assign mstatus_en  = csr_mstatus_write_valid_i || sel_mstatus;
  assign mstatus_din = csr_mstatus_write_valid_i ? csr_mstatus_write_data_i : csr_write_data_i;

  assign mepc_en  = csr_mepc_write_valid_i || sel_mepc;
  assign mepc_din = csr_mepc_write_valid_i ? csr_mepc_write_data_i : csr_write_data_i;

  assign mcause_en  = csr_mcause_write_valid_i || sel_mcause;
  assign mcause_din = csr_mcause_write_valid_i ? csr_mcause_write_data_i : csr_write_data_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      mstatus_q  <= `MSTATUS_RESET;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (mstatus_en) begin
        // read-only fields are reloaded from the reset pattern
        mstatus_q <= (mstatus_din & `MSTATUS_WMASK) | (`MSTATUS_RESET & ~`MSTATUS_WMASK);
      end
      if (sel_mtvec) begin
        mtvec_q <= csr_write_data_i & ALIGN_MASK;  // direct mode, base is word aligned
      end
      if (sel_mscratch) begin
        mscratch_q <= csr_write_data_i;
      end
      if (mepc_en) begin
        mepc_q <= mepc_din & ALIGN_MASK;
      end
      if (mcause_en) begin
        mcause_q <= mcause_din;
      end
    end
  end

  always_comb begin
    case (csr_read_addr_i)
      CSR_MSTATUS:  csr_read_data_o = mstatus_q;
      CSR_MTVEC:    csr_read_data_o = mtvec_q;
      CSR_MSCRATCH: csr_read_data_o = mscratch_q;
      CSR_MEPC:     csr_read_data_o = mepc_q;
      CSR_MCAUSE:   csr_read_data_o = mcause_q;
      default:      csr_read_data_o = '0;  // unimplemented numbers read as zero
    endcase
  end

  assign csr_mstatus_o = mstatus_q;
  assign csr_mepc_o    = mepc_q;
  assign csr_mtvec_o   = mtvec_q;

endmodule

//--- rtl/csr_unit.sv
`include "csr_config.svh"

module csr_unit (
  input  logic                        clk,
  input  logic                        reset_i,
  input  csr_pkg::csr_op_e            csr_op_i,
  input  logic [`CSR_ADDR_WIDTH-1:0]  csr_addr_i,
  input  logic [`DATA_WIDTH-1:0]      csr_wdata_i,
  input  logic                        trap_i,
  input  logic                        mret_i,
  input  logic [`DATA_WIDTH-1:0]      trap_pc_i,
  input  logic [`DATA_WIDTH-1:0]      trap_cause_i,
  output logic [`DATA_WIDTH-1:0]      csr_rdata_o,
  output logic                        csr_illegal_o,
  output logic                        redirect_valid_o,
  output logic [`DATA_WIDTH-1:0]      redirect_pc_o,
  output logic [`DATA_WIDTH-1:0]      mstatus_o
);

  logic                   csr_we;
  logic [`DATA_WIDTH-1:0] csr_wr_data;
  logic                   trap_active;

  logic                   mstatus_valid;
  logic [`DATA_WIDTH-1:0] mstatus_data;
  logic                   mepc_valid;
  logic [`DATA_WIDTH-1:0] mepc_data;
  logic                   mcause_valid;
  logic [`DATA_WIDTH-1:0] mcause_data;

  logic [`DATA_WIDTH-1:0] mepc;
  logic [`DATA_WIDTH-1:0] mtvec;

  csr_exec u_exec (
    .csr_op_i      (csr_op_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .old_data_i    (csr_rdata_o),  // same value the instruction returns
    .trap_active_i (trap_active),
    .csr_illegal_o (csr_illegal_o),
    .wr_valid_o    (csr_we),
    .wr_data_o     (csr_wr_data)
  );

  csr_trap_ctrl u_trap_ctrl (
    .trap_i           (trap_i),
    .mret_i           (mret_i),
    .trap_pc_i        (trap_pc_i),
    .trap_cause_i     (trap_cause_i),
    .mstatus_i        (mstatus_o),
    .mepc_i           (mepc),
    .mtvec_i          (mtvec),
    .trap_active_o    (trap_active),
    .mstatus_valid_o  (mstatus_valid),
    .mstatus_data_o   (mstatus_data),
    .mepc_valid_o     (mepc_valid),
    .mepc_data_o      (mepc_data),
    .mcause_valid_o   (mcause_valid),
    .mcause_data_o    (mcause_data),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o)
  );

  csr_regfile u_regfile (
    .clk                       (clk),
    .reset_i                   (reset_i),
    .csr_mstatus_write_valid_i (mstatus_valid),
    .csr_mstatus_write_data_i  (mstatus_data),
    .csr_mepc_write_valid_i    (mepc_valid),
    .csr_mepc_write_data_i     (mepc_data),
    .csr_mcause_write_valid_i  (mcause_valid),
    .csr_mcause_write_data_i   (mcause_data),
    .csr_write_valid_i         (csr_we),
    .csr_write_addr_i          (csr_addr_i),
    .csr_write_data_i          (csr_wr_data),
    .csr_read_addr_i           (csr_addr_i),
    .csr_read_data_o           (csr_rdata_o),
    .csr_mstatus_o             (mstatus_o),  // also read by the core for MIE
    .csr_mepc_o                (mepc),
    .csr_mtvec_o               (mtvec)
  );

endmodule

//--- verif/csr_unit_checker.sv
`include "csr_config.svh"

module csr_unit_checker (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    trap_i,
  input  logic                    mret_i,
  input  logic                    redirect_valid_i,
  input  logic [`DATA_WIDTH-1:0]  rdata_i,
  input  logic                    illegal_i,
  input  logic [`DATA_WIDTH-1:0]  mstatus_i
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int MPP_LO = 11;
  localparam int MPP_HI = 12;

  // the fetch stage only gets redirected by a trap or an mret
  redirect_source_a: assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_valid_i |-> (trap_i || mret_i))
    else $error("redirect raised without trap or mret");

  illegal_reads_zero_a: assert property (@(posedge clk_i) disable iff (reset_i)
    illegal_i |-> (rdata_i == '0))
    else $error("illegal CSR access returned nonzero read data");

  // MPP is hardwired to machine mode
  mpp_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $stable(mstatus_i[MPP_HI:MPP_LO]))
    else $error("mstatus MPP field changed");

  mstatus_reset_a: assert property (@(posedge clk_i)
    reset_i |=> (mstatus_i == `MSTATUS_RESET))
    else $error("mstatus does not hold its reset value after reset");

endmodule

bind csr_unit csr_unit_checker u_checker (
  .clk_i            (clk),
  .reset_i          (reset_i),
  .trap_i           (trap_i),
  .mret_i           (mret_i),
  .redirect_valid_i (redirect_valid_o),
  .rdata_i          (csr_rdata_o),
  .illegal_i        (csr_illegal_o),
  .mstatus_i        (mstatus_o)
);

//--- verif/csr_unit_tb.sv
`include "csr_config.svh"

module csr_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import csr_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int TABLE_SIZE   = 48;
  localparam int RANDOM_COUNT = 300;

  localparam logic [11:0] A_MSTATUS  = 12'h300;
  localparam logic [11:0] A_MTVEC    = 12'h305;
  localparam logic [11:0] A_MSCRATCH = 12'h340;
  localparam logic [11:0] A_MEPC     = 12'h341;
  localparam logic [11:0] A_MCAUSE   = 12'h342;
  localparam logic [11:0] A_UNUSED   = 12'h7c0;  // not implemented here

  logic clk;
  logic reset_i;
  csr_op_e csr_op_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic trap_i;
  logic mret_i;
  logic [31:0] trap_pc_i;
  logic [31:0] trap_cause_i;
  logic [31:0] csr_rdata_o;
  logic csr_illegal_o;
  logic redirect_valid_o;
  logic [31:0] redirect_pc_o;
  logic [31:0] mstatus_o;

  // stimulus and expected values with one entry per cycle
  csr_op_e     t_op     [TABLE_SIZE];
  logic [11:0] t_addr   [TABLE_SIZE];
  logic [31:0] t_data   [TABLE_SIZE];
  logic        t_trap   [TABLE_SIZE];
  logic        t_mret   [TABLE_SIZE];
  logic [31:0] t_pc     [TABLE_SIZE];
  logic [31:0] t_cause  [TABLE_SIZE];
  logic [31:0] e_rdata  [TABLE_SIZE];
  logic        e_illegal[TABLE_SIZE];
  logic        e_redir  [TABLE_SIZE];
  logic [31:0] e_pc     [TABLE_SIZE];
  logic [31:0] e_mstatus[TABLE_SIZE];

  int n_rows;
  int error_count;
  integer seed;
  logic table_ready;

  // reference copies of the five CSRs
  logic [31:0] m_mstatus;
  logic [31:0] m_mtvec;
  logic [31:0] m_mscratch;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;

  csr_unit dut_i (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("FAIL at time %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "output mismatch, run stopped");
    end
  endtask

  task automatic add_row(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data,
                         input logic trap, input logic mret, input logic [31:0] pc,
                         input logic [31:0] cause);
    t_op[n_rows]    = op;
    t_addr[n_rows]  = addr;
    t_data[n_rows]  = data;
    t_trap[n_rows]  = trap;
    t_mret[n_rows]  = mret;
    t_pc[n_rows]    = pc;
    t_cause[n_rows] = cause;
    n_rows++;
  endtask

  // outputs come from the old state and the edge update follows
  task automatic model_step(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data,
                            input logic trap, input logic mret, input logic [31:0] pc,
                            input logic [31:0] cause, output logic [31:0] rdata,
                            output logic illegal, output logic redir,
                            output logic [31:0] redir_pc, output logic [31:0] mstatus);
    logic legal;
    logic [31:0] old;
    logic [31:0] nv;
    legal = 1'b1;
    old = '0;
    case (addr)
      A_MSTATUS:  old = m_mstatus;
      A_MTVEC:    old = m_mtvec;
      A_MSCRATCH: old = m_mscratch;
      A_MEPC:     old = m_mepc;
      A_MCAUSE:   old = m_mcause;
      default:    legal = 1'b0;
    endcase
    rdata = old;
    illegal = (op != CSR_NONE) && !legal;
    mstatus = m_mstatus;
    redir = trap || mret;
    redir_pc = trap ? (m_mtvec & ~32'h3) : m_mepc;
    nv = old;
    if (trap) begin
      m_mepc = pc & ~32'h3;
      m_mcause = cause;
      m_mstatus[`MSTATUS_MPIE_BIT] = m_mstatus[`MSTATUS_MIE_BIT];
      m_mstatus[`MSTATUS_MIE_BIT] = 1'b0;
    end else if (mret) begin
      m_mstatus[`MSTATUS_MIE_BIT] = m_mstatus[`MSTATUS_MPIE_BIT];
      m_mstatus[`MSTATUS_MPIE_BIT] = 1'b1;
    end else if (op != CSR_NONE && legal) begin
      case (op)
        CSR_RW:  nv = data;
        CSR_RS:  nv = old | data;
        default: nv = old & ~data;
      endcase
      case (addr)
        A_MSTATUS: begin
          // only the two enable bits follow the written value
          m_mstatus[`MSTATUS_MIE_BIT]  = nv[`MSTATUS_MIE_BIT];
          m_mstatus[`MSTATUS_MPIE_BIT] = nv[`MSTATUS_MPIE_BIT];
        end
        A_MTVEC:    m_mtvec = nv & ~32'h3;
        A_MSCRATCH: m_mscratch = nv;
        A_MEPC:     m_mepc = nv & ~32'h3;
        default:    m_mcause = nv;
      endcase
    end
  endtask

  task automatic fill_table();
    // reset values and an unused number read without an operation
    add_row(CSR_NONE, A_MSTATUS, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MTVEC, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSCRATCH, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MEPC, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MCAUSE, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_UNUSED, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_MSCRATCH, 32'hdead_beef, 0, 0, 0, 0);
    add_row(CSR_RS, A_MSCRATCH, 32'h0000_00f0, 0, 0, 0, 0);
    add_row(CSR_RC, A_MSCRATCH, 32'hdead_0000, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSCRATCH, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_MTVEC, 32'h8000_0103, 0, 0, 0, 0);
    add_row(CSR_RS, A_MTVEC, 32'h0000_0006, 0, 0, 0, 0);
    add_row(CSR_RC, A_MTVEC, 32'h0000_0100, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MTVEC, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_MSTATUS, 32'hffff_ffff, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSTATUS, 0, 0, 0, 0, 0);
    add_row(CSR_RC, A_MSTATUS, 32'h0000_0008, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSTATUS, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_UNUSED, 32'hffff_ffff, 0, 0, 0, 0);
    add_row(CSR_RS, 12'h001, 32'h0000_0001, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSCRATCH, 0, 0, 0, 0, 0);
    // MIE set and MPIE clear make the trap shuffle visible
    add_row(CSR_RS, A_MSTATUS, 32'h0000_0008, 0, 0, 0, 0);
    add_row(CSR_RC, A_MSTATUS, 32'h0000_0080, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSTATUS, 0, 1, 0, 32'h1000_0206, 32'h0000_000b);
    add_row(CSR_NONE, A_MEPC, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MCAUSE, 0, 0, 0, 0, 0);
    add_row(CSR_NONE, A_MSTATUS, 0, 0, 1, 0, 0);
    add_row(CSR_NONE, A_MSTATUS, 0, 0, 0, 0, 0);
    // instruction writes squashed by a trap or mret in the same cycle
    add_row(CSR_RW, A_MSCRATCH, 32'h0000_0055, 1, 0, 32'h2000_0010, 32'h0000_0002);
    add_row(CSR_NONE, A_MSCRATCH, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_MEPC, 32'hffff_ffff, 1, 0, 32'h3000_0008, 32'h0000_0007);
    add_row(CSR_NONE, A_MEPC, 0, 0, 0, 0, 0);
    add_row(CSR_RW, A_MSTATUS, 32'h0000_0000, 0, 1, 0, 0);
    add_row(CSR_RW, A_MTVEC, 32'h0000_0000, 1, 1, 32'h4000_0004, 32'h0000_0003);
    add_row(CSR_NONE, A_MTVEC, 0, 0, 0, 0, 0);
  endtask

  task automatic drive_cycle(input csr_op_e op, input logic [11:0] addr, input logic [31:0] data,
                             input logic trap, input logic mret, input logic [31:0] pc,
                             input logic [31:0] cause);
    @(posedge clk);
    csr_op_i     <= op;
    csr_addr_i   <= addr;
    csr_wdata_i  <= data;
    trap_i       <= trap;
    mret_i       <= mret;
    trap_pc_i    <= pc;
    trap_cause_i <= cause;
  endtask

  // outputs are settled by the falling edge
  task automatic check_outputs(input string tag, input logic [31:0] rdata, input logic illegal,
                               input logic redir, input logic [31:0] redir_pc,
                               input logic [31:0] mstatus);
    @(negedge clk);
    check_value({tag, " rdata"}, csr_rdata_o, rdata);
    check_value({tag, " illegal"}, {31'b0, csr_illegal_o}, {31'b0, illegal});
    check_value({tag, " redirect valid"}, {31'b0, redirect_valid_o}, {31'b0, redir});
    if (redir) begin
      check_value({tag, " redirect pc"}, redirect_pc_o, redir_pc);
    end
    check_value({tag, " mstatus"}, mstatus_o, mstatus);
  endtask

  initial begin
    wait (table_ready);
    #((n_rows + RANDOM_COUNT + RESET_CYCLES) * CLK_PERIOD * 2);
    $display("Simulation failed");
    $fatal(1, "watchdog expired before the test finished");
  end

  initial begin
    logic [11:0] addr_pool [6];
    csr_op_e op;
    logic [11:0] addr;
    logic [31:0] data;
    logic trap;
    logic mret;
    logic [31:0] pc;
    logic [31:0] cause;
    logic [31:0] x_rdata;
    logic x_illegal;
    logic x_redir;
    logic [31:0] x_pc;
    logic [31:0] x_mstatus;
    clk = 1'b0;
    reset_i = 1'b1;
    csr_op_i = CSR_NONE;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    trap_i = 1'b0;
    mret_i = 1'b0;
    trap_pc_i = '0;
    trap_cause_i = '0;
    seed = 1;
    error_count = 0;
    n_rows = 0;
    table_ready = 1'b0;
    addr_pool = '{A_MSTATUS, A_MTVEC, A_MSCRATCH, A_MEPC, A_MCAUSE, A_UNUSED};
    m_mstatus = `MSTATUS_RESET;
    m_mtvec = '0;
    m_mscratch = '0;
    m_mepc = '0;
    m_mcause = '0;
    fill_table();
    for (int i = 0; i < n_rows; i++) begin
      model_step(t_op[i], t_addr[i], t_data[i], t_trap[i], t_mret[i], t_pc[i], t_cause[i],
                 e_rdata[i], e_illegal[i], e_redir[i], e_pc[i], e_mstatus[i]);
    end
    table_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_i <= 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      drive_cycle(t_op[i], t_addr[i], t_data[i], t_trap[i], t_mret[i], t_pc[i], t_cause[i]);
      check_outputs($sformatf("row %0d", i), e_rdata[i], e_illegal[i], e_redir[i], e_pc[i],
                    e_mstatus[i]);
    end
    // the model carries on from the state the table left behind
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      data = $random(seed);
      op = csr_op_e'(data[1:0]);
      addr = addr_pool[$unsigned($random(seed)) % 6];
      data = $random(seed);
      trap = ($random(seed) & 7) == 0;
      mret = ($random(seed) & 7) == 0;
      pc = $random(seed);
      cause = $random(seed);
      model_step(op, addr, data, trap, mret, pc, cause, x_rdata, x_illegal, x_redir, x_pc,
                 x_mstatus);
      drive_cycle(op, addr, data, trap, mret, pc, cause);
      check_outputs($sformatf("random %0d", i), x_rdata, x_illegal, x_redir, x_pc, x_mstatus);
    end
    drive_cycle(CSR_NONE, '0, '0, 1'b0, 1'b0, '0, '0);
    @(negedge clk);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_exec.sv
rtl/csr_trap_ctrl.sv
rtl/csr_regfile.sv
rtl/csr_unit.sv
verif/csr_unit_checker.sv
verif/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/csr_pkg.sv
      - rtl/csr_exec.sv
      - rtl/csr_trap_ctrl.sv
      - rtl/csr_regfile.sv
      - rtl/csr_unit.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/csr_unit_checker.sv
      - verif/csr_unit_tb.sv
